// ==== design/mmu_pkg.sv ====
// shared widths, enums and constants of the Sv32 MMU; every RTL module imports this package
package mmu_pkg;

    // datapath widths
    localparam int XLEN  = 32;
    localparam int VPN_W = 10;
    localparam int PPN_W = 20;

    // access kind of a request, also selects the TLB
    typedef enum logic [1:0] {
        ACC_NONE  = 2'd0,
        ACC_CODE  = 2'd1,
        ACC_READ  = 2'd2,
        ACC_WRITE = 2'd3
    } access_t;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_t;

    // page walker FSM
    typedef enum logic [2:0] {
        WS_IDLE    = 3'd0,
        WS_L1_READ = 3'd1,
        WS_L1_WAIT = 3'd2,
        WS_L0_READ = 3'd3,
        WS_L0_WAIT = 3'd4,
        WS_DECIDE  = 3'd5,
        WS_UPDATE  = 3'd6,
        WS_HIT     = 3'd7
    } walk_state_t;

    // page-table entry bits
    localparam int PTE_V = 0;
    localparam int PTE_R = 1;
    localparam int PTE_W = 2;
    localparam int PTE_X = 3;
    localparam int PTE_U = 4;
    localparam int PTE_A = 6;
    localparam int PTE_D = 7;

    // page-fault causes, as in mcause
    localparam logic [XLEN-1:0] CAUSE_FETCH_PF = 32'd12;
    localparam logic [XLEN-1:0] CAUSE_LOAD_PF  = 32'd13;
    localparam logic [XLEN-1:0] CAUSE_STORE_PF = 32'd15;

endpackage

// ==== design/sv32_tlb.sv ====
// direct-mapped TLB for one access kind; combinational lookup, filled by the page walker
`timescale 1ns/1ps

module sv32_tlb
    import mmu_pkg::*;
#(
    parameter int TLB_ENTRIES = 4
) (
    input  logic               CLK,
    input  logic               i_rst_n,
    input  logic               i_flush,
    input  logic               i_fill,
    input  logic [2*VPN_W-1:0] i_lookup_vpn,
    input  logic [2*VPN_W-1:0] i_fill_vpn,
    input  logic [PPN_W-1:0]   i_fill_ppn,
    output logic               o_hit,
    output logic [PPN_W-1:0]   o_ppn
);

    localparam int IDX_W = $clog2(TLB_ENTRIES);
    localparam int TAG_W = 2*VPN_W - IDX_W;

    logic [TLB_ENTRIES-1:0] valid;
    logic [TAG_W-1:0]       tag_mem [TLB_ENTRIES];
    logic [PPN_W-1:0]       ppn_mem [TLB_ENTRIES];

    logic [IDX_W-1:0]       lk_idx;
    logic [TAG_W-1:0]       lk_tag;
    logic [IDX_W-1:0]       fl_idx;
    logic [TAG_W-1:0]       fl_tag;

    // low vpn bits index, the rest is the tag
    assign lk_idx = i_lookup_vpn[IDX_W-1:0];
    assign lk_tag = i_lookup_vpn[2*VPN_W-1:IDX_W];
    assign fl_idx = i_fill_vpn[IDX_W-1:0];
    assign fl_tag = i_fill_vpn[2*VPN_W-1:IDX_W];

    assign o_hit = valid[lk_idx] && (tag_mem[lk_idx] == lk_tag);
    assign o_ppn = ppn_mem[lk_idx];

    always_ff @(posedge CLK or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid <= '0;
        end else if (i_flush) begin
            valid <= '0;
        end else if (i_fill) begin
            valid[fl_idx] <= 1'b1;
        end
    end

    // entry contents
    always_ff @(posedge CLK) begin
        if (i_fill) begin
            tag_mem[fl_idx] <= fl_tag;
            ppn_mem[fl_idx] <= i_fill_ppn;
        end
    end

    // walker fills only while busy, flush arrives only while it is idle
    a_no_fill_on_flush: assert property (
        @(posedge CLK) disable iff (!i_rst_n) !(i_fill && i_flush)
    ) else $error("tlb fill and flush in the same cycle");

endmodule

// ==== design/pte_check.sv ====
// combinational decode of one Sv32 page-table entry against the current access
`timescale 1ns/1ps

module pte_check
    import mmu_pkg::*;
(
    input  logic [XLEN-1:0] i_pte,
    input  access_t         i_acc,
    input  priv_t           i_priv,
    input  logic            i_sum,
    input  logic            i_mxr,
    output logic            o_valid,
    output logic            o_leaf,
    output logic            o_ok,
    output logic            o_need_update,
    output logic [XLEN-1:0] o_pte_upd
);

    logic [2:0] xwr;
    logic [2:0] xwr_eff;
    logic       perm_hit;
    logic       bad_encoding;
    logic       priv_fault;

    // bit 0 read, bit 1 write, bit 2 execute
    assign xwr = i_pte[PTE_X:PTE_R];
    // MXR lets an executable page be read
    assign xwr_eff = {xwr[2], xwr[1], xwr[0] | (i_mxr & xwr[2])};

    assign o_valid = i_pte[PTE_V];
    assign o_leaf  = (xwr != 3'b000);

    always_comb begin
        case (i_acc)
            ACC_CODE:  perm_hit = xwr_eff[2];
            ACC_READ:  perm_hit = xwr_eff[0];
            ACC_WRITE: perm_hit = xwr_eff[1];
            default:   perm_hit = 1'b0;
        endcase
    end

    // write without read is a reserved encoding
    assign bad_encoding = xwr[1] && !xwr[0];

    // S mode never fetches from a user page, SUM only opens loads and stores
    always_comb begin
        case (i_priv)
            PRIV_U:  priv_fault = !i_pte[PTE_U];
            PRIV_S:  priv_fault = i_pte[PTE_U] && (!i_sum || i_acc == ACC_CODE);
            default: priv_fault = 1'b0;
        endcase
    end

    assign o_ok = perm_hit && !bad_encoding && !priv_fault;

    // accessed always, dirty on a store
    always_comb begin
        o_pte_upd = i_pte;
        o_pte_upd[PTE_A] = 1'b1;
        if (i_acc == ACC_WRITE) begin
            o_pte_upd[PTE_D] = 1'b1;
        end
    end

    assign o_need_update = (o_pte_upd != i_pte);

endmodule

// ==== design/page_walker.sv ====
// Sv32 walk FSM; answers TLB hits, reads both PTE levels, writes back A/D and fills the TLB
`timescale 1ns/1ps

module page_walker
    import mmu_pkg::*;
(
    input  logic             CLK,
    input  logic             i_rst_n,
    input  logic             i_start,
    input  access_t          i_acc,
    input  logic [XLEN-1:0]  i_vaddr,
    input  logic [PPN_W-1:0] i_root_ppn,
    input  logic             i_tlb_hit,
    input  logic [PPN_W-1:0] i_tlb_ppn,
    input  logic [XLEN-1:0]  i_mem_rdata,
    input  logic             i_l1_valid,
    input  logic             i_l1_leaf,
    input  logic             i_l1_ok,
    input  logic             i_l1_need_update,
    input  logic [XLEN-1:0]  i_l1_pte_upd,
    input  logic             i_l0_valid,
    input  logic             i_l0_leaf,
    input  logic             i_l0_ok,
    input  logic             i_l0_need_update,
    input  logic [XLEN-1:0]  i_l0_pte_upd,
    output logic [XLEN-1:0]  o_l1_pte,
    output logic [XLEN-1:0]  o_l0_pte,
    output logic             o_fill,
    output logic [PPN_W-1:0] o_fill_ppn,
    output logic             o_mem_re,
    output logic             o_mem_we,
    output logic [XLEN-1:0]  o_mem_addr,
    output logic [XLEN-1:0]  o_mem_wdata,
    output logic             o_done,
    output logic [XLEN-1:0]  o_paddr,
    output logic             o_fault,
    output logic [XLEN-1:0]  o_cause
);

    walk_state_t      state;
    logic             at_l0;
    logic             done_q;
    logic             fault_q;
    logic [XLEN-1:0]  paddr_q;
    logic [XLEN-1:0]  l1_pte_q;
    logic [XLEN-1:0]  l0_pte_q;

    logic [VPN_W-1:0] vpn1;
    logic [VPN_W-1:0] vpn0;
    logic [XLEN-1:0]  l1_addr;
    logic [XLEN-1:0]  l0_addr;
    logic [XLEN-1:0]  walk_paddr;
    logic             walk_ok;
    logic             need_wb;
    logic [XLEN-1:0]  fault_cause;

    assign vpn1 = i_vaddr[31:22];
    assign vpn0 = i_vaddr[21:12];
    assign l1_addr = {i_root_ppn, vpn1, 2'b00};
    assign l0_addr = {l1_pte_q[29:10], vpn0, 2'b00};

    // level-1 entry is checked straight off the bus while it arrives
    assign o_l1_pte = (state == WS_L1_WAIT) ? i_mem_rdata : l1_pte_q;
    assign o_l0_pte = l0_pte_q;

    // a superpage also needs its low PPN field clear
    assign walk_ok = at_l0 ? (i_l0_valid && i_l0_leaf && i_l0_ok)
                           : (i_l1_valid && i_l1_leaf && i_l1_ok && l1_pte_q[19:10] == '0);
    assign walk_paddr = at_l0 ? {l0_pte_q[29:10], i_vaddr[11:0]}
                              : {l1_pte_q[29:20], i_vaddr[21:0]};
    assign need_wb = at_l0 ? i_l0_need_update : i_l1_need_update;

    // TLB keeps 4 KiB pages, superpages included
    assign o_fill     = (state == WS_DECIDE) && walk_ok;
    assign o_fill_ppn = walk_paddr[31:12];

    always_ff @(posedge CLK or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= WS_IDLE;
            at_l0   <= 1'b0;
            fault_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= (state == WS_HIT);
            case (state)
                WS_IDLE: begin
                    if (i_start) begin
                        at_l0   <= 1'b0;
                        fault_q <= 1'b0;
                        state   <= i_tlb_hit ? WS_HIT : WS_L1_READ;
                    end
                end
                WS_L1_READ: state <= WS_L1_WAIT;
                WS_L1_WAIT: begin
                    // valid non-leaf points to the next level
                    if (i_l1_valid && !i_l1_leaf) begin
                        at_l0 <= 1'b1;
                        state <= WS_L0_READ;
                    end else begin
                        state <= WS_DECIDE;
                    end
                end
                WS_L0_READ: state <= WS_L0_WAIT;
                WS_L0_WAIT: state <= WS_DECIDE;
                WS_DECIDE: begin
                    fault_q <= !walk_ok;
                    state   <= (walk_ok && need_wb) ? WS_UPDATE : WS_HIT;
                end
                WS_UPDATE: state <= WS_HIT;
                WS_HIT:    state <= WS_IDLE;
            endcase
        end
    end

    // entries and result address
    always_ff @(posedge CLK) begin
        case (state)
            WS_IDLE:    paddr_q <= {i_tlb_ppn, i_vaddr[11:0]};
            WS_L1_WAIT: l1_pte_q <= i_mem_rdata;
            WS_L0_WAIT: l0_pte_q <= i_mem_rdata;
            WS_DECIDE:  paddr_q <= walk_ok ? walk_paddr : '0;
            default:    ;
        endcase
    end

    always_comb begin
        o_mem_re   = 1'b0;
        o_mem_we   = 1'b0;
        o_mem_addr = '0;
        case (state)
            WS_L1_READ: begin
                o_mem_re   = 1'b1;
                o_mem_addr = l1_addr;
            end
            WS_L0_READ: begin
                o_mem_re   = 1'b1;
                o_mem_addr = l0_addr;
            end
            WS_UPDATE: begin
                o_mem_we   = 1'b1;
                o_mem_addr = at_l0 ? l0_addr : l1_addr;
            end
            default: ;
        endcase
    end

    assign o_mem_wdata = at_l0 ? i_l0_pte_upd : i_l1_pte_upd;

    always_comb begin
        case (i_acc)
            ACC_CODE:  fault_cause = CAUSE_FETCH_PF;
            ACC_WRITE: fault_cause = CAUSE_STORE_PF;
            default:   fault_cause = CAUSE_LOAD_PF;
        endcase
    end

    assign o_done  = done_q;
    assign o_paddr = paddr_q;
    assign o_fault = done_q && fault_q;
    assign o_cause = o_fault ? fault_cause : '0;

    a_mem_strobes: assert property (
        @(posedge CLK) disable iff (!i_rst_n) !(o_mem_re && o_mem_we)
    ) else $error("memory read and write strobes overlap");

    a_done_pulse: assert property (
        @(posedge CLK) disable iff (!i_rst_n) o_done |=> !o_done
    ) else $error("o_done held longer than one cycle");

endmodule

// ==== design/sv32_mmu.sv ====
// Sv32 MMU top level; bypass path, per-access TLBs, PTE checkers and page walker
`timescale 1ns/1ps

module sv32_mmu
    import mmu_pkg::*;
#(
    parameter int TLB_ENTRIES = 4
) (
    input  logic            CLK,
    input  logic            i_rst_n,
    input  logic            i_req,
    input  access_t         i_acc,
    input  logic [XLEN-1:0] i_vaddr,
    input  priv_t           i_priv,
    input  logic [XLEN-1:0] i_satp,
    input  logic            i_sum,
    input  logic            i_mxr,
    input  logic            i_flush,
    input  logic [XLEN-1:0] i_mem_rdata,
    output logic            o_done,
    output logic [XLEN-1:0] o_paddr,
    output logic            o_fault,
    output logic [XLEN-1:0] o_cause,
    output logic            o_mem_re,
    output logic            o_mem_we,
    output logic [XLEN-1:0] o_mem_addr,
    output logic [XLEN-1:0] o_mem_wdata
);

    logic             busy;
    logic             accept;
    logic             bypass;
    logic             walk_start;
    logic             byp_done;
    logic [XLEN-1:0]  byp_paddr;

    logic             hit_code;
    logic             hit_load;
    logic             hit_store;
    logic [PPN_W-1:0] ppn_code;
    logic [PPN_W-1:0] ppn_load;
    logic [PPN_W-1:0] ppn_store;
    logic             sel_hit;
    logic [PPN_W-1:0] sel_ppn;

    logic             w_fill;
    logic [PPN_W-1:0] w_fill_ppn;
    logic             w_done;
    logic [XLEN-1:0]  w_paddr;
    logic             w_fault;
    logic [XLEN-1:0]  w_cause;

    logic [XLEN-1:0]  l1_pte;
    logic [XLEN-1:0]  l0_pte;
    logic             l1_valid;
    logic             l1_leaf;
    logic             l1_ok;
    logic             l1_need_update;
    logic [XLEN-1:0]  l1_pte_upd;
    logic             l0_valid;
    logic             l0_leaf;
    logic             l0_ok;
    logic             l0_need_update;
    logic [XLEN-1:0]  l0_pte_upd;

    // no translation in M mode, with satp off, or without an access kind
    assign bypass     = (i_priv == PRIV_M) || !i_satp[31] || (i_acc == ACC_NONE);
    assign accept     = i_req && !busy;
    assign walk_start = accept && !bypass;

    always_ff @(posedge CLK or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy     <= 1'b0;
            byp_done <= 1'b0;
        end else begin
            byp_done <= accept && bypass;
            if (accept) begin
                busy <= 1'b1;
            end else if (o_done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        byp_paddr <= i_vaddr;
    end

    always_comb begin
        case (i_acc)
            ACC_CODE: begin
                sel_hit = hit_code;
                sel_ppn = ppn_code;
            end
            ACC_READ: begin
                sel_hit = hit_load;
                sel_ppn = ppn_load;
            end
            ACC_WRITE: begin
                sel_hit = hit_store;
                sel_ppn = ppn_store;
            end
            default: begin
                sel_hit = 1'b0;
                sel_ppn = '0;
            end
        endcase
    end

    sv32_tlb #(.TLB_ENTRIES(TLB_ENTRIES)) u_tlb_code (
        .CLK(CLK), .i_rst_n(i_rst_n), .i_flush(i_flush),
        .i_fill(w_fill && i_acc == ACC_CODE),
        .i_lookup_vpn(i_vaddr[31:12]), .i_fill_vpn(i_vaddr[31:12]), .i_fill_ppn(w_fill_ppn),
        .o_hit(hit_code), .o_ppn(ppn_code)
    );

    sv32_tlb #(.TLB_ENTRIES(TLB_ENTRIES)) u_tlb_load (
        .CLK(CLK), .i_rst_n(i_rst_n), .i_flush(i_flush),
        .i_fill(w_fill && i_acc == ACC_READ),
        .i_lookup_vpn(i_vaddr[31:12]), .i_fill_vpn(i_vaddr[31:12]), .i_fill_ppn(w_fill_ppn),
        .o_hit(hit_load), .o_ppn(ppn_load)
    );

    sv32_tlb #(.TLB_ENTRIES(TLB_ENTRIES)) u_tlb_store (
        .CLK(CLK), .i_rst_n(i_rst_n), .i_flush(i_flush),
        .i_fill(w_fill && i_acc == ACC_WRITE),
        .i_lookup_vpn(i_vaddr[31:12]), .i_fill_vpn(i_vaddr[31:12]), .i_fill_ppn(w_fill_ppn),
        .o_hit(hit_store), .o_ppn(ppn_store)
    );

    pte_check u_chk_l1 (
        .i_pte(l1_pte), .i_acc(i_acc), .i_priv(i_priv), .i_sum(i_sum), .i_mxr(i_mxr),
        .o_valid(l1_valid), .o_leaf(l1_leaf), .o_ok(l1_ok),
        .o_need_update(l1_need_update), .o_pte_upd(l1_pte_upd)
    );

    pte_check u_chk_l0 (
        .i_pte(l0_pte), .i_acc(i_acc), .i_priv(i_priv), .i_sum(i_sum), .i_mxr(i_mxr),
        .o_valid(l0_valid), .o_leaf(l0_leaf), .o_ok(l0_ok),
        .o_need_update(l0_need_update), .o_pte_upd(l0_pte_upd)
    );

    page_walker u_walker (
        .CLK(CLK), .i_rst_n(i_rst_n), .i_start(walk_start), .i_acc(i_acc),
        .i_vaddr(i_vaddr), .i_root_ppn(i_satp[PPN_W-1:0]),
        .i_tlb_hit(sel_hit), .i_tlb_ppn(sel_ppn), .i_mem_rdata(i_mem_rdata),
        .i_l1_valid(l1_valid), .i_l1_leaf(l1_leaf), .i_l1_ok(l1_ok),
        .i_l1_need_update(l1_need_update), .i_l1_pte_upd(l1_pte_upd),
        .i_l0_valid(l0_valid), .i_l0_leaf(l0_leaf), .i_l0_ok(l0_ok),
        .i_l0_need_update(l0_need_update), .i_l0_pte_upd(l0_pte_upd),
        .o_l1_pte(l1_pte), .o_l0_pte(l0_pte), .o_fill(w_fill), .o_fill_ppn(w_fill_ppn),
        .o_mem_re(o_mem_re), .o_mem_we(o_mem_we),
        .o_mem_addr(o_mem_addr), .o_mem_wdata(o_mem_wdata),
        .o_done(w_done), .o_paddr(w_paddr), .o_fault(w_fault), .o_cause(w_cause)
    );

    // bypass never faults
    assign o_done  = byp_done || w_done;
    assign o_paddr = byp_done ? byp_paddr : w_paddr;
    assign o_fault = w_fault;
    assign o_cause = w_cause;

endmodule

// ==== tb/mmu_mem_model.sv ====
// word memory that holds the page tables for the MMU testbench; reads answer one cycle later
`timescale 1ns/1ps

module mmu_mem_model (
    input  logic        CLK,
    input  logic        i_rst_n,
    input  logic        i_re,
    input  logic        i_we,
    input  logic [31:0] i_addr,
    input  logic [31:0] i_wdata,
    output logic [31:0] o_rdata,
    input  logic        i_load_we,
    input  logic [31:0] i_load_addr,
    input  logic [31:0] i_load_data,
    input  logic [31:0] i_peek_addr,
    output logic [31:0] o_peek_data,
    output logic [31:0] o_reads,
    output logic [31:0] o_writes
);

    // 16 KiB, byte address bits 13:2 select the word
    logic [31:0] words [4096];

    // MMU writes win, the preload port is only used while the MMU is idle
    always_ff @(posedge CLK) begin
        if (i_we) begin
            words[i_addr[13:2]] <= i_wdata;
        end else if (i_load_we) begin
            words[i_load_addr[13:2]] <= i_load_data;
        end
    end

    always_ff @(posedge CLK or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rdata  <= '0;
            o_reads  <= '0;
            o_writes <= '0;
        end else begin
            if (i_re) begin
                o_rdata <= words[i_addr[13:2]];
                o_reads <= o_reads + 32'd1;
            end
            if (i_we) begin
                o_writes <= o_writes + 32'd1;
            end
        end
    end

    // side view for checking entries after the run
    assign o_peek_data = words[i_peek_addr[13:2]];

endmodule

// ==== tb/mmu_tb.sv ====
// testbench for the Sv32 MMU; preloads page tables, applies the request table and checks answers
`timescale 1ns/1ps

module mmu_tb
    import mmu_pkg::*;
();

    localparam int NROWS   = 32;
    localparam int TIMEOUT = 50;

    // root table at 0x1000, one level-0 table at 0x2000
    localparam logic [31:0] ROOT_BASE = 32'h0000_1000;
    localparam logic [31:0] L0_BASE   = 32'h0000_2000;
    localparam logic [31:0] SATP_ON   = 32'h8000_0001;
    localparam logic [31:0] SATP_OFF  = 32'h0000_0001;

    localparam logic [7:0] F_V = 8'h01;
    localparam logic [7:0] F_R = 8'h02;
    localparam logic [7:0] F_W = 8'h04;
    localparam logic [7:0] F_X = 8'h08;
    localparam logic [7:0] F_U = 8'h10;
    localparam logic [7:0] F_A = 8'h40;
    localparam logic [7:0] F_D = 8'h80;

    localparam logic [31:0] PF_FETCH = 32'd12;
    localparam logic [31:0] PF_LOAD  = 32'd13;
    localparam logic [31:0] PF_STORE = 32'd15;

    // leaf pages and their initial flags
    localparam logic [19:0] PPN_A   = 20'h12345;
    localparam logic [19:0] PPN_B   = 20'h23456;
    localparam logic [19:0] PPN_RO  = 20'h34567;
    localparam logic [19:0] PPN_U   = 20'h45678;
    localparam logic [19:0] PPN_INV = 20'h6789A;
    localparam logic [19:0] PPN_XO  = 20'h56789;
    localparam logic [19:0] PPN_SUP = 20'h2AC00;
    localparam logic [7:0]  FL_A    = F_R | F_W | F_X | F_V;
    localparam logic [7:0]  FL_B    = F_R | F_W | F_A | F_D | F_V;
    localparam logic [7:0]  FL_RO   = F_R | F_A | F_V;
    localparam logic [7:0]  FL_U    = F_R | F_W | F_U | F_V;
    localparam logic [7:0]  FL_INV  = F_R | F_W;
    localparam logic [7:0]  FL_XO   = F_X | F_V;
    localparam logic [7:0]  FL_SUP  = F_R | F_W | F_X | F_A | F_D | F_V;

    localparam logic [31:0] VA_A   = 32'h0040_0000;
    localparam logic [31:0] VA_B   = 32'h0040_1000;
    localparam logic [31:0] VA_RO  = 32'h0040_2000;
    localparam logic [31:0] VA_U   = 32'h0040_3000;
    localparam logic [31:0] VA_INV = 32'h0040_4000;
    localparam logic [31:0] VA_XO  = 32'h0040_5000;
    localparam logic [31:0] VA_SUP = 32'h0081_5000;
    localparam logic [31:0] VA_OFF = 32'h1234_5000;
    localparam logic [31:0] PA_A   = {PPN_A, 12'h000};
    localparam logic [31:0] PA_B   = {PPN_B, 12'h000};
    localparam logic [31:0] PA_RO  = {PPN_RO, 12'h000};
    localparam logic [31:0] PA_U   = {PPN_U, 12'h000};
    localparam logic [31:0] PA_XO  = {PPN_XO, 12'h000};
    // superpage keeps the low 22 bits of the virtual address
    localparam logic [31:0] PA_SUP = {PPN_SUP[19:10], VA_SUP[21:0]};

    // row control bits
    localparam logic [6:0] K_SATP  = 7'h01;
    localparam logic [6:0] K_SUM   = 7'h02;
    localparam logic [6:0] K_MXR   = 7'h04;
    localparam logic [6:0] K_FLUSH = 7'h08;
    localparam logic [6:0] K_FAULT = 7'h10;
    localparam logic [6:0] K_WALK  = 7'h20;
    localparam logic [6:0] K_WR    = 7'h40;

    logic        CLK = 1'b0;
    logic        rst_n;
    logic        req;
    access_t     acc;
    logic [31:0] vaddr;
    priv_t       priv;
    logic [31:0] satp;
    logic        sum;
    logic        mxr;
    logic        flush;
    logic        done;
    logic [31:0] paddr;
    logic        fault;
    logic [31:0] cause;
    logic        mem_re;
    logic        mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic        load_we;
    logic [31:0] load_addr;
    logic [31:0] load_data;
    logic [31:0] peek_addr;
    logic [31:0] peek_data;
    logic [31:0] reads;
    logic [31:0] writes;

    string       row_name [NROWS];
    access_t     row_acc [NROWS];
    priv_t       row_priv [NROWS];
    logic [31:0] row_va [NROWS];
    logic [31:0] row_exp [NROWS];
    logic [6:0]  row_ctl [NROWS];
    int          nrows = 0;
    int          errors = 0;
    int          checks = 0;
    logic        timed_out = 1'b0;

    sv32_mmu #(.TLB_ENTRIES(4)) uut (
        .CLK(CLK), .i_rst_n(rst_n), .i_req(req), .i_acc(acc), .i_vaddr(vaddr),
        .i_priv(priv), .i_satp(satp), .i_sum(sum), .i_mxr(mxr), .i_flush(flush),
        .i_mem_rdata(mem_rdata), .o_done(done), .o_paddr(paddr), .o_fault(fault),
        .o_cause(cause), .o_mem_re(mem_re), .o_mem_we(mem_we),
        .o_mem_addr(mem_addr), .o_mem_wdata(mem_wdata)
    );

    mmu_mem_model mem (
        .CLK(CLK), .i_rst_n(rst_n), .i_re(mem_re), .i_we(mem_we), .i_addr(mem_addr),
        .i_wdata(mem_wdata), .o_rdata(mem_rdata), .i_load_we(load_we),
        .i_load_addr(load_addr), .i_load_data(load_data), .i_peek_addr(peek_addr),
        .o_peek_data(peek_data), .o_reads(reads), .o_writes(writes)
    );

    always #50 CLK = ~CLK;

    function automatic logic [31:0] make_pte(input logic [19:0] ppn, input logic [7:0] flags);
        return {2'b00, ppn, 2'b00, flags};
    endfunction

    // Sv32 entry addresses: table base plus VPN field times four
    function automatic logic [31:0] root_slot(input logic [31:0] va);
        return ROOT_BASE | {20'd0, va[31:22], 2'b00};
    endfunction

    function automatic logic [31:0] l0_slot(input logic [31:0] va);
        return L0_BASE | {20'd0, va[21:12], 2'b00};
    endfunction

    task automatic expect_equal(input string test, input string what,
                                input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            $display("ERROR %s %s: expected 0x%08h actual 0x%08h", test, what, exp, act);
            errors++;
        end
    endtask

    task automatic add_row(input string name, input access_t a, input priv_t p,
                           input logic [31:0] va, input logic [31:0] expv,
                           input logic [6:0] ctl);
        row_name[nrows] = name;
        row_acc[nrows]  = a;
        row_priv[nrows] = p;
        row_va[nrows]   = va;
        row_exp[nrows]  = expv;
        row_ctl[nrows]  = ctl;
        nrows++;
    endtask

    task automatic load_word(input logic [31:0] addr, input logic [31:0] data);
        @(posedge CLK);
        load_we   <= 1'b1;
        load_addr <= addr;
        load_data <= data;
    endtask

    task automatic check_pte(input string test, input logic [31:0] addr,
                             input logic [31:0] exp);
        @(posedge CLK);
        peek_addr <= addr;
        @(negedge CLK);
        expect_equal(test, "pte", exp, peek_data);
    endtask

    task automatic run_row(input int r);
        logic [31:0] off;
        logic [31:0] reads0;
        logic [31:0] writes0;
        logic [6:0]  ctl;
        int          waited;
        ctl = row_ctl[r];
        off = $urandom & 32'hFFF;
        if (|(ctl & K_FLUSH)) begin
            @(posedge CLK);
            flush <= 1'b1;
            @(posedge CLK);
            flush <= 1'b0;
        end
        @(posedge CLK);
        reads0  = reads;
        writes0 = writes;
        req     <= 1'b1;
        acc     <= row_acc[r];
        priv    <= row_priv[r];
        vaddr   <= row_va[r] | off;
        satp    <= (|(ctl & K_SATP)) ? SATP_ON : SATP_OFF;
        sum     <= |(ctl & K_SUM);
        mxr     <= |(ctl & K_MXR);
        @(posedge CLK);
        req <= 1'b0;
        waited = 0;
        @(negedge CLK);
        while (!done && waited < TIMEOUT) begin
            @(negedge CLK);
            waited++;
        end
        if (!done) begin
            $display("timeout: test %s got no o_done within %0d cycles", row_name[r], TIMEOUT);
            errors++;
            timed_out = 1'b1;
        end else begin
            expect_equal(row_name[r], "fault", 32'(|(ctl & K_FAULT)), 32'(fault));
            if (|(ctl & K_FAULT)) begin
                expect_equal(row_name[r], "cause", row_exp[r], cause);
            end else begin
                expect_equal(row_name[r], "paddr", row_exp[r] | off, paddr);
                expect_equal(row_name[r], "cause", 32'd0, cause);
            end
            expect_equal(row_name[r], "walk", 32'(|(ctl & K_WALK)), 32'(reads != reads0));
            expect_equal(row_name[r], "writeback", 32'(|(ctl & K_WR)), writes - writes0);
        end
    endtask

    initial begin
        void'($urandom(36));
        rst_n     = 1'b0;
        req       = 1'b0;
        acc       = ACC_NONE;
        vaddr     = '0;
        priv      = PRIV_M;
        satp      = '0;
        sum       = 1'b0;
        mxr       = 1'b0;
        flush     = 1'b0;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        peek_addr = '0;

        add_row("bypass_mmode", ACC_READ, PRIV_M, VA_A, VA_A, K_SATP);
        add_row("bypass_satp_off", ACC_WRITE, PRIV_S, VA_OFF, VA_OFF, 7'h00);
        add_row("load_walk_a", ACC_READ, PRIV_S, VA_A, PA_A, K_SATP | K_WALK | K_WR);
        add_row("load_hit_a", ACC_READ, PRIV_S, VA_A, PA_A, K_SATP);
        add_row("store_walk_a", ACC_WRITE, PRIV_S, VA_A, PA_A, K_SATP | K_WALK | K_WR);
        add_row("store_walk_b", ACC_WRITE, PRIV_S, VA_B, PA_B, K_SATP | K_WALK);
        add_row("store_hit_b", ACC_WRITE, PRIV_S, VA_B, PA_B, K_SATP);
        add_row("super_load", ACC_READ, PRIV_S, VA_SUP, PA_SUP, K_SATP | K_WALK);
        add_row("super_hit", ACC_READ, PRIV_S, VA_SUP, PA_SUP, K_SATP);
        add_row("store_ro_fault", ACC_WRITE, PRIV_S, VA_RO, PF_STORE, K_SATP | K_WALK | K_FAULT);
        add_row("store_ro_again", ACC_WRITE, PRIV_S, VA_RO, PF_STORE, K_SATP | K_WALK | K_FAULT);
        add_row("load_ro", ACC_READ, PRIV_S, VA_RO, PA_RO, K_SATP | K_WALK);
        add_row("fetch_umode_s_page", ACC_CODE, PRIV_U, VA_A, PF_FETCH, K_SATP | K_WALK | K_FAULT);
        add_row("fetch_umode_again", ACC_CODE, PRIV_U, VA_A, PF_FETCH, K_SATP | K_WALK | K_FAULT);
        add_row("load_u_page_nosum", ACC_READ, PRIV_S, VA_U, PF_LOAD, K_SATP | K_WALK | K_FAULT);
        add_row("load_u_page_sum", ACC_READ, PRIV_S, VA_U, PA_U, K_SATP | K_SUM | K_WALK | K_WR);
        add_row("store_u_page_umode", ACC_WRITE, PRIV_U, VA_U, PA_U, K_SATP | K_WALK | K_WR);
        add_row("load_xonly_fault", ACC_READ, PRIV_S, VA_XO, PF_LOAD, K_SATP | K_WALK | K_FAULT);
        add_row("load_xonly_mxr", ACC_READ, PRIV_S, VA_XO, PA_XO, K_SATP | K_MXR | K_WALK | K_WR);
        add_row("load_invalid", ACC_READ, PRIV_S, VA_INV, PF_LOAD, K_SATP | K_WALK | K_FAULT);
        add_row("load_invalid_again", ACC_READ, PRIV_S, VA_INV, PF_LOAD, K_SATP | K_WALK | K_FAULT);
        add_row("load_a_after_flush", ACC_READ, PRIV_S, VA_A, PA_A, K_SATP | K_FLUSH | K_WALK);
        add_row("load_a_hit_again", ACC_READ, PRIV_S, VA_A, PA_A, K_SATP);

        repeat (4) @(posedge CLK);
        rst_n <= 1'b1;

        // pointer to the level-0 table and a superpage at level 1
        load_word(root_slot(VA_A), make_pte(L0_BASE[31:12], F_V));
        load_word(root_slot(VA_SUP), make_pte(PPN_SUP, FL_SUP));
        load_word(l0_slot(VA_A), make_pte(PPN_A, FL_A));
        load_word(l0_slot(VA_B), make_pte(PPN_B, FL_B));
        load_word(l0_slot(VA_RO), make_pte(PPN_RO, FL_RO));
        load_word(l0_slot(VA_U), make_pte(PPN_U, FL_U));
        load_word(l0_slot(VA_INV), make_pte(PPN_INV, FL_INV));
        load_word(l0_slot(VA_XO), make_pte(PPN_XO, FL_XO));
        @(posedge CLK);
        load_we <= 1'b0;

        for (int r = 0; r < nrows && !timed_out; r++) begin
            run_row(r);
        end

        // A set by every successful access, D only by stores
        check_pte("pte_a_final", l0_slot(VA_A), make_pte(PPN_A, FL_A | F_A | F_D));
        check_pte("pte_b_final", l0_slot(VA_B), make_pte(PPN_B, FL_B));
        check_pte("pte_ro_final", l0_slot(VA_RO), make_pte(PPN_RO, FL_RO));
        check_pte("pte_u_final", l0_slot(VA_U), make_pte(PPN_U, FL_U | F_A | F_D));
        check_pte("pte_xo_final", l0_slot(VA_XO), make_pte(PPN_XO, FL_XO | F_A));

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== sv32_mmu.f ====
design/mmu_pkg.sv
design/sv32_tlb.sv
design/pte_check.sv
design/page_walker.sv
design/sv32_mmu.sv
tb/mmu_mem_model.sv
tb/mmu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the MMU testbench with Verilator, runs it and decides the result from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module mmu_tb -Mdir "$OBJ" -f sv32_mmu.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/Vmmu_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
